// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_id_stage
FILELIST  ?= list.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

obj_dir/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

// File: id_branch_unit.sv
// branch unit: resolves branches and jumps in decode and drives the redirect bus to fetch
module id_branch_unit (
  input  id_pkg::word_t    i_pc,
  input  id_pkg::word_t    i_fs_pc,
  input  id_pkg::word_t    i_rs1data,
  input  id_pkg::word_t    i_rs2data,
  input  id_pkg::word_t    i_imm,
  input  logic             i_bren,
  input  id_pkg::br_func_e i_brfunc,
  output id_pkg::br_bus_t  o_br_bus
);
  import id_pkg::*;

  logic  cond;
  word_t base;
  word_t sum;

  always_comb begin
    case (i_brfunc)
      BR_BEQ:  cond = (i_rs1data == i_rs2data);
      BR_BNE:  cond = (i_rs1data != i_rs2data);
      BR_BLT:  cond = ($signed(i_rs1data) < $signed(i_rs2data));
      BR_BGE:  cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      BR_JAL,
      BR_JALR: cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign base = (i_brfunc == BR_JALR) ? i_rs1data : i_pc;
  assign sum  = base + i_imm;

  assign o_br_bus.sel    = i_bren && cond;
  assign o_br_bus.target = (i_brfunc == BR_JALR) ? {sum[63:1], 1'b0} : sum;
  // no redirect while fetch is already on the right path
  assign o_br_bus.taken  = o_br_bus.sel && (o_br_bus.target != i_fs_pc);

endmodule

// File: id_consts.svh
// decode stage constants: widths, register counts and rv64 opcode encodings
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define XLEN         64
`define INST_W       32
`define GPR_ADDR_W   5
`define GPR_NUM      32
`define NUM_BYPASS   3  // execute, memory, writeback
`define NUM_RD_PORTS 2
`define A0_REG       10 // ebreak result register

// base opcodes in inst[6:0]
`define OP_IMM       7'b0010011
`define OP           7'b0110011
`define LUI          7'b0110111
`define AUIPC        7'b0010111
`define JAL          7'b1101111
`define JALR         7'b1100111
`define BRANCH       7'b1100011
`define LOAD         7'b0000011
`define STORE        7'b0100011
`define SYSTEM       7'b1110011

// funct fields of the kept subset
`define F3_ADD       3'b000
`define F3_BEQ       3'b000
`define F3_BNE       3'b001
`define F3_BLT       3'b100
`define F3_BGE       3'b101
`define F3_D         3'b011 // ld / sd
`define F7_BASE      7'b0000000
`define F7_SUB       7'b0100000
`define EBREAK_INST  32'h0010_0073

`endif

// File: id_decoder.sv
// instruction decoder for the rv64 integer subset: indices, immediate and control
`include "id_consts.svh"

module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs [`NUM_RD_PORTS],
  output id_pkg::word_t     o_imm,
  output id_pkg::dec_ctrl_t o_ctrl,
  output logic              o_bren,
  output id_pkg::br_func_e  o_brfunc
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode  = i_inst[6:0];
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign o_rs[0] = i_inst[19:15];
  assign o_rs[1] = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl          = '0;
    o_ctrl.alu_src1 = SRC1_RS1;
    o_ctrl.alu_src2 = SRC2_RS2;
    o_ctrl.alu_op   = ALU_ADD;
    o_imm           = imm_i;
    o_bren          = 1'b0;
    o_brfunc        = BR_BEQ;
    case (opcode)
      `OP_IMM: begin
        if (funct3 == `F3_ADD) begin // addi
          o_ctrl.alu_src2 = SRC2_IMM;
          o_ctrl.gpr_wen  = 1'b1;
        end else begin
          o_ctrl.invalid_inst_sel = 1'b1;
        end
      end
      `OP: begin
        if (funct3 == `F3_ADD && funct7 == `F7_BASE) begin
          o_ctrl.gpr_wen = 1'b1;
        end else if (funct3 == `F3_ADD && funct7 == `F7_SUB) begin
          o_ctrl.alu_op  = ALU_SUB;
          o_ctrl.gpr_wen = 1'b1;
        end else begin
          o_ctrl.invalid_inst_sel = 1'b1;
        end
      end
      `LUI: begin
        o_imm           = imm_u;
        o_ctrl.alu_src2 = SRC2_IMM;
        o_ctrl.alu_op   = ALU_PASS_B;
        o_ctrl.gpr_wen  = 1'b1;
      end
      `AUIPC: begin
        o_imm           = imm_u;
        o_ctrl.alu_src1 = SRC1_PC;
        o_ctrl.alu_src2 = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      `JAL: begin
        o_imm           = imm_j;
        o_ctrl.alu_src1 = SRC1_PC; // rd = pc + 4
        o_ctrl.alu_src2 = SRC2_FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_bren          = 1'b1;
        o_brfunc        = BR_JAL;
      end
      `JALR: begin
        if (funct3 == `F3_ADD) begin
          o_ctrl.alu_src1 = SRC1_PC;
          o_ctrl.alu_src2 = SRC2_FOUR;
          o_ctrl.gpr_wen  = 1'b1;
          o_bren          = 1'b1;
          o_brfunc        = BR_JALR;
        end else begin
          o_ctrl.invalid_inst_sel = 1'b1;
        end
      end
      `BRANCH: begin
        o_imm  = imm_b;
        o_bren = 1'b1;
        case (funct3)
          `F3_BEQ: o_brfunc = BR_BEQ;
          `F3_BNE: o_brfunc = BR_BNE;
          `F3_BLT: o_brfunc = BR_BLT;
          `F3_BGE: o_brfunc = BR_BGE;
          default: begin
            o_bren                  = 1'b0;
            o_ctrl.invalid_inst_sel = 1'b1;
          end
        endcase
      end
      `LOAD: begin
        if (funct3 == `F3_D) begin // ld
          o_ctrl.alu_src2 = SRC2_IMM;
          o_ctrl.gpr_wen  = 1'b1;
          o_ctrl.mem_ren  = 1'b1;
          o_ctrl.mem_op   = funct3;
        end else begin
          o_ctrl.invalid_inst_sel = 1'b1;
        end
      end
      `STORE: begin
        o_imm = imm_s;
        if (funct3 == `F3_D) begin // sd
          o_ctrl.alu_src2 = SRC2_IMM;
          o_ctrl.mem_wen  = 1'b1;
          o_ctrl.mem_op   = funct3;
        end else begin
          o_ctrl.invalid_inst_sel = 1'b1;
        end
      end
      `SYSTEM: begin
        if (i_inst == `EBREAK_INST) o_ctrl.ebreak_sel = 1'b1;
        else o_ctrl.invalid_inst_sel = 1'b1;
      end
      default: o_ctrl.invalid_inst_sel = 1'b1;
    endcase
    o_ctrl.rd = o_ctrl.gpr_wen ? i_inst[11:7] : '0; // zero rd marks no write downstream
  end

endmodule

// File: id_gpr_file.sv
// general register file: 32 x 64, combinational reads, one write port, x0 fixed at zero
`include "id_consts.svh"

module id_gpr_file (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  id_pkg::gpr_addr_t i_raddr [`NUM_RD_PORTS],
  output id_pkg::word_t     o_rdata [`NUM_RD_PORTS],
  input  id_pkg::wb_gpr_t   i_wb
);
  import id_pkg::*;

  word_t regs [`GPR_NUM];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && i_wb.addr != '0) begin
      regs[i_wb.addr] <= i_wb.data;
    end
  end

  // a same-cycle write reaches the operands through forwarding
  always_comb begin
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      o_rdata[p] = (i_raddr[p] == '0) ? '0 : regs[i_raddr[p]];
    end
  end

endmodule

// File: id_gpr_forward.sv
// operand forwarding: picks one source operand from the bypass buses or the register file
`include "id_consts.svh"

module id_gpr_forward (
  input  id_pkg::gpr_addr_t i_rs,
  input  id_pkg::word_t     i_rf_data,
  input  id_pkg::bypass_t   i_bypass [`NUM_BYPASS],
  output id_pkg::word_t     o_data
);
  import id_pkg::*;

  // walk oldest to youngest so execute overrides memory and writeback
  always_comb begin
    o_data = i_rf_data;
    for (int i = `NUM_BYPASS - 1; i >= 0; i--) begin
      if (i_bypass[i].rd != '0 && i_bypass[i].rd == i_rs) begin
        o_data = i_bypass[i].result;
      end
    end
  end

endmodule

// File: id_pkg.sv
// decode stage package: vector types, operation enums and stage buses
`include "id_consts.svh"

package id_pkg;

  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`INST_W-1:0]     inst_t;
  typedef logic [`GPR_ADDR_W-1:0] gpr_addr_t;

  typedef enum logic [4:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_PASS_B = 5'd2   // lui
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1 = 1'b0,
    SRC1_PC  = 1'b1
  } alu_src1_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2    // link address for jal / jalr
  } alu_src2_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'd0,
    BR_BNE  = 3'd1,
    BR_BLT  = 3'd2,
    BR_BGE  = 3'd3,
    BR_JAL  = 3'd4,
    BR_JALR = 3'd5
  } br_func_e;

  typedef struct packed {
    inst_t inst;
    word_t pc;
  } fs_to_ds_t;

  // rd of zero means the stage writes nothing
  typedef struct packed {
    gpr_addr_t rd;
    word_t     result;
  } bypass_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t addr;
    word_t     data;
  } wb_gpr_t;

  typedef struct packed {
    logic  taken;
    logic  sel;
    word_t target;
  } br_bus_t;

  typedef struct packed {
    alu_src1_e alu_src1;
    alu_src2_e alu_src2;
    alu_op_e   alu_op;
    gpr_addr_t rd;
    logic      gpr_wen;
    logic      mem_ren;
    logic      mem_wen;
    logic [2:0] mem_op;  // funct3 of ld / sd
    logic      ebreak_sel;
    logic      invalid_inst_sel;
  } dec_ctrl_t;

  typedef struct packed {
    word_t     rs1data;
    word_t     rs2data;
    word_t     imm;
    word_t     pc;
    dec_ctrl_t ctrl;
  } ds_to_es_t;

endpackage

// File: id_stage.sv
// decode stage top: slot, decoder, register file, operand forwarding and branch unit
`include "id_consts.svh"

module id_stage (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t i_fs_to_ds,
  input  logic              i_es_allowin,
  input  id_pkg::wb_gpr_t   i_wb,
  input  id_pkg::bypass_t   i_bypass [`NUM_BYPASS],
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::ds_to_es_t o_ds_to_es,
  output id_pkg::br_bus_t   o_br_bus
);
  import id_pkg::*;

  fs_to_ds_t slot;
  gpr_addr_t rs [`NUM_RD_PORTS];
  word_t     rf_data [`NUM_RD_PORTS];
  word_t     fwd_data [`NUM_RD_PORTS];
  word_t     imm;
  dec_ctrl_t ctrl;
  logic      bren;
  logic      br_en;
  br_func_e  brfunc;

  id_stage_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds       (i_fs_to_ds),
    .i_es_allowin     (i_es_allowin),
    .i_br_taken       (o_br_bus.taken),
    .i_ebreak_sel     (ctrl.ebreak_sel),
    .i_bypass         (i_bypass),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_slot           (slot)
  );

  id_decoder u_dec (
    .i_inst   (slot.inst),
    .o_rs     (rs),
    .o_imm    (imm),
    .o_ctrl   (ctrl),
    .o_bren   (bren),
    .o_brfunc (brfunc)
  );

  id_gpr_file u_gpr (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_raddr (rs),
    .o_rdata (rf_data),
    .i_wb    (i_wb)
  );

  for (genvar p = 0; p < `NUM_RD_PORTS; p++) begin : g_fwd
    id_gpr_forward u_fwd (
      .i_rs      (rs[p]),
      .i_rf_data (rf_data[p]),
      .i_bypass  (i_bypass),
      .o_data    (fwd_data[p])
    );
  end

  assign br_en = bren && o_ds_to_es_valid; // empty slot never redirects

  id_branch_unit u_bru (
    .i_pc      (slot.pc),
    .i_fs_pc   (i_fs_to_ds.pc),
    .i_rs1data (fwd_data[0]),
    .i_rs2data (fwd_data[1]),
    .i_imm     (imm),
    .i_bren    (br_en),
    .i_brfunc  (brfunc),
    .o_br_bus  (o_br_bus)
  );

  assign o_ds_to_es = '{
    rs1data: fwd_data[0],
    rs2data: fwd_data[1],
    imm:     imm,
    pc:      slot.pc,
    ctrl:    ctrl
  };

  // the inst fetch presents during a redirect must not reach execute
  a_squash: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_bus.taken && o_ds_allowin |=> !o_ds_to_es_valid)
    else $error("wrong-path inst survived a redirect");

endmodule

// File: id_stage_ctrl.sv
// decode slot control: input register, valid/allowin handshake, squash and ebreak stall
`include "id_consts.svh"

module id_stage_ctrl (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t i_fs_to_ds,
  input  logic              i_es_allowin,
  input  logic              i_br_taken,
  input  logic              i_ebreak_sel,
  input  id_pkg::bypass_t   i_bypass [`NUM_BYPASS],
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::fs_to_ds_t o_slot
);
  import id_pkg::*;

  logic      ds_valid;
  logic      a0_pending;
  logic      ready_go;
  fs_to_ds_t slot_q;

  // a later stage still owes a0
  always_comb begin
    a0_pending = 1'b0;
    for (int i = 0; i < `NUM_BYPASS; i++) begin
      if (i_bypass[i].rd == gpr_addr_t'(`A0_REG)) a0_pending = 1'b1;
    end
  end

  assign ready_go         = ~(i_ebreak_sel && a0_pending);
  assign o_ds_allowin     = !ds_valid || (ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ready_go;
  assign o_slot           = slot_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !i_br_taken; // wrong-path inst dropped
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) slot_q <= i_fs_to_ds;
  end

  // an outgoing inst was really loaded from fetch
  a_out_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_ds_to_es_valid |-> !$isunknown(slot_q))
    else $error("decode output valid without a loaded slot");

  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_ds_to_es_valid && !i_es_allowin |=> ds_valid && $stable(slot_q))
    else $error("decode slot changed under back-pressure");

endmodule

// File: list.f
+incdir+.
id_pkg.sv
id_stage_ctrl.sv
id_decoder.sv
id_gpr_file.sv
id_gpr_forward.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

// File: tb_id_stage.sv
// testbench for the decode stage: random decode, forwarding, branch, stall and hold checks
`include "id_consts.svh"

module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import id_pkg::*;

  localparam int N_TESTS      = 83;
  localparam int CYC_PER_TEST = 12;

  logic      clk;
  logic      rst_n;
  logic      fs_valid;
  fs_to_ds_t fs;
  logic      es_allowin;
  wb_gpr_t   wb;
  bypass_t   bypass [`NUM_BYPASS];
  logic      ds_allowin;
  logic      ds_valid;
  ds_to_es_t ds_out;
  br_bus_t   br_bus;

  logic [31:0] lfsr = 32'h6408;
  word_t       gpr_model [`GPR_NUM];
  bypass_t     bp_plan [`NUM_BYPASS];
  string       test_name = "reset";
  int          errors = 0;
  int          tests_run = 0;

  // expected values and check enables
  dec_ctrl_t exp_ctrl;
  word_t     exp_imm, exp_pc, exp_rs1, exp_rs2, exp_tgt;
  logic      exp_sel, exp_taken, imm_en;
  logic      chk_rst, chk_dec, chk_opnd, chk_br, chk_sq, chk_stall, chk_go, chk_hold;

  id_stage i_id_stage (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds       (fs),
    .i_es_allowin     (es_allowin),
    .i_wb             (wb),
    .i_bypass         (bypass),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (ds_valid),
    .o_ds_to_es       (ds_out),
    .o_br_bus         (br_bus)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(N_TESTS * CYC_PER_TEST * 2 * 20);
    $display("watchdog expired before all tests finished");
    $display("TB FAILED");
    $finish;
  end

  // galois lfsr stepped once per bit
  function automatic logic [63:0] rnd(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic word_t fwd_model(input gpr_addr_t rs);
    if (rs == '0) return '0;
    for (int i = 0; i < `NUM_BYPASS; i++) begin
      if (bp_plan[i].rd == rs) return bp_plan[i].result; // execute first
    end
    return gpr_model[rs];
  endfunction

  task automatic mismatch(input string what, input logic [255:0] e, input logic [255:0] a);
    errors++;
    $display("Error %s (%s): expected %h actual %h", test_name, what, e, a);
  endtask

  task automatic flag_failure(input string msg);
    errors++;
    $display("test %s: %s", test_name, msg);
  endtask

  task automatic finish_test();
    tests_run++;
    $display("test %s done, %0d errors so far", test_name, errors);
  endtask

  // present one inst and wait for the edge that takes it
  task automatic issue(input inst_t inst, input word_t pc);
    @(posedge clk);
    fs_valid <= 1'b1;
    fs       <= '{inst: inst, pc: pc};
    do @(posedge clk); while (!ds_allowin);
  endtask

  a_reset: assert property (@(posedge clk) chk_rst |-> !ds_valid && !br_bus.taken)
    else flag_failure("valid or taken high after reset");

  a_dec: assert property (@(posedge clk)
    chk_dec |-> ds_valid && ds_out.ctrl == exp_ctrl && ds_out.pc == exp_pc)
    else mismatch("ctrl/pc", {exp_ctrl, exp_pc}, {$sampled(ds_out.ctrl), $sampled(ds_out.pc)});

  a_imm: assert property (@(posedge clk) chk_dec && imm_en |-> ds_out.imm == exp_imm)
    else mismatch("imm", exp_imm, $sampled(ds_out.imm));

  a_opnd: assert property (@(posedge clk)
    chk_opnd |-> ds_out.rs1data == exp_rs1 && ds_out.rs2data == exp_rs2)
    else mismatch("operands", {exp_rs1, exp_rs2},
                  {$sampled(ds_out.rs1data), $sampled(ds_out.rs2data)});

  a_br: assert property (@(posedge clk) chk_br |-> br_bus.sel == exp_sel
    && br_bus.taken == exp_taken && (!exp_sel || br_bus.target == exp_tgt))
    else mismatch("taken/sel/target", {exp_taken, exp_sel, exp_tgt}, $sampled(br_bus));

  a_squash: assert property (@(posedge clk) chk_sq |-> !ds_valid)
    else flag_failure("wrong-path inst reached execute");

  a_stall: assert property (@(posedge clk) chk_stall |-> !ds_valid && !ds_allowin)
    else flag_failure("ebreak went on while a0 was still pending");

  a_go: assert property (@(posedge clk) chk_go |-> ds_valid)
    else flag_failure("ebreak stayed stalled after a0 cleared");

  a_hold: assert property (@(posedge clk) chk_hold |-> ds_valid && $stable(ds_out))
    else flag_failure("output changed under back-pressure");

  task automatic decode_test(input int kind);
    string      names [8];
    gpr_addr_t  rd, rs1, rs2;
    logic [11:0] i12;
    logic [19:0] u20;
    inst_t      inst;
    word_t      pc, imm;
    dec_ctrl_t  c;
    names = '{"addi", "add", "sub", "lui", "auipc", "ld", "sd", "unknown"};
    test_name = names[kind];
    rd  = gpr_addr_t'(rnd(5));
    rs1 = gpr_addr_t'(rnd(5));
    rs2 = gpr_addr_t'(rnd(5));
    i12 = 12'(rnd(12));
    u20 = 20'(rnd(20));
    pc  = rnd(62) << 2;
    c   = '0;
    imm = {{52{i12[11]}}, i12};
    imm_en = 1'b1;
    case (kind)
      0: begin
        inst = {i12, rs1, `F3_ADD, rd, `OP_IMM};
        c.alu_src2 = SRC2_IMM;
        c.gpr_wen  = 1'b1;
      end
      1, 2: begin
        inst = {(kind == 2) ? `F7_SUB : `F7_BASE, rs2, rs1, `F3_ADD, rd, `OP};
        c.alu_op  = (kind == 2) ? ALU_SUB : ALU_ADD;
        c.gpr_wen = 1'b1;
        imm_en    = 1'b0;
      end
      3, 4: begin
        inst = {u20, rd, (kind == 3) ? `LUI : `AUIPC};
        imm  = {{32{u20[19]}}, u20, 12'b0};
        c.alu_src1 = (kind == 4) ? SRC1_PC : SRC1_RS1;
        c.alu_src2 = SRC2_IMM;
        c.alu_op   = (kind == 3) ? ALU_PASS_B : ALU_ADD;
        c.gpr_wen  = 1'b1;
      end
      5: begin
        inst = {i12, rs1, `F3_D, rd, `LOAD};
        c.alu_src2 = SRC2_IMM;
        c.gpr_wen  = 1'b1;
        c.mem_ren  = 1'b1;
        c.mem_op   = `F3_D;
      end
      6: begin
        inst = {i12[11:5], rs2, rs1, `F3_D, i12[4:0], `STORE};
        c.alu_src2 = SRC2_IMM;
        c.mem_wen  = 1'b1;
        c.mem_op   = `F3_D;
      end
      default: begin
        inst = {25'(rnd(25)), 7'b0001011}; // custom-0 lies outside the subset
        c.invalid_inst_sel = 1'b1;
        imm_en = 1'b0;
      end
    endcase
    if (c.gpr_wen) c.rd = rd;
    issue(inst, pc);
    fs_valid <= 1'b0;
    exp_ctrl = c;
    exp_imm  = imm;
    exp_pc   = pc;
    chk_dec <= 1'b1;
    @(posedge clk);
    chk_dec <= 1'b0;
    finish_test();
  endtask

  task automatic forward_test();
    gpr_addr_t rd, rs1, rs2;
    logic [1:0] mode;
    test_name = "forward";
    rd  = gpr_addr_t'(rnd(5));
    rs1 = gpr_addr_t'(rnd(5));
    rs2 = gpr_addr_t'(rnd(5));
    for (int i = 0; i < `NUM_BYPASS; i++) begin
      mode = 2'(rnd(2));
      bp_plan[i].rd = (mode == 0) ? rs1 : (mode == 1) ? rs2 :
                      (mode == 2) ? gpr_addr_t'(0) : gpr_addr_t'(rnd(5));
      bp_plan[i].result = rnd(64);
    end
    issue({`F7_BASE, rs2, rs1, `F3_ADD, rd, `OP}, rnd(62) << 2);
    fs_valid <= 1'b0;
    for (int i = 0; i < `NUM_BYPASS; i++) bypass[i] <= bp_plan[i];
    exp_rs1 = fwd_model(rs1);
    exp_rs2 = fwd_model(rs2);
    chk_opnd <= 1'b1;
    @(posedge clk);
    chk_opnd <= 1'b0;
    for (int i = 0; i < `NUM_BYPASS; i++) bypass[i] <= '0;
    finish_test();
  endtask

  task automatic branch_test(input int kind);
    string       names [6];
    logic [2:0]  f3s [4];
    gpr_addr_t   rd, rs1, rs2;
    logic [12:0] i13;
    logic [20:0] i21;
    logic [11:0] i12;
    word_t       pc, a, b, fpc;
    inst_t       inst;
    names = '{"beq", "bne", "blt", "bge", "jal", "jalr"};
    f3s   = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE};
    test_name = names[kind];
    rd  = gpr_addr_t'(rnd(5));
    rs1 = gpr_addr_t'(rnd(5));
    rs2 = rnd(1) ? rs1 : gpr_addr_t'(rnd(5));
    i13 = {12'(rnd(12)), 1'b0};
    i21 = {20'(rnd(20)), 1'b0};
    i12 = 12'(rnd(12));
    pc  = rnd(62) << 2;
    a   = gpr_model[rs1];
    b   = gpr_model[rs2];
    exp_tgt = pc + {{51{i13[12]}}, i13};
    case (kind)
      0: exp_sel = (a == b);
      1: exp_sel = (a != b);
      2: exp_sel = ($signed(a) < $signed(b));
      3: exp_sel = ($signed(a) >= $signed(b));
      default: exp_sel = 1'b1;
    endcase
    if (kind < 4) begin
      inst = {i13[12], i13[10:5], rs2, rs1, f3s[kind], i13[4:1], i13[11], `BRANCH};
    end else if (kind == 4) begin
      inst    = {i21[20], i21[10:1], i21[11], i21[19:12], rd, `JAL};
      exp_tgt = pc + {{43{i21[20]}}, i21};
    end else begin
      inst    = {i12, rs1, `F3_ADD, rd, `JALR};
      exp_tgt = (a + {{52{i12[11]}}, i12}) & ~64'd1;
    end
    fpc = rnd(1) ? exp_tgt : exp_tgt + 64'd4;
    exp_taken = exp_sel && (fpc != exp_tgt);
    issue(inst, pc);
    fs <= '{inst: {12'd0, 5'd0, `F3_ADD, 5'd0, `OP_IMM}, pc: fpc}; // nop at the fetch pc
    chk_br <= 1'b1;
    @(posedge clk);
    chk_br   <= 1'b0;
    fs_valid <= 1'b0;
    chk_sq   <= exp_taken;
    @(posedge clk);
    chk_sq <= 1'b0;
    finish_test();
  endtask

  task automatic ebreak_test();
    int k;
    test_name = "ebreak";
    k = int'(rnd(2)) % `NUM_BYPASS;
    issue(`EBREAK_INST, rnd(62) << 2);
    fs_valid <= 1'b0;
    bypass[k] <= '{rd: gpr_addr_t'(`A0_REG), result: rnd(64)};
    chk_stall <= 1'b1;
    repeat (3) @(posedge clk);
    chk_stall <= 1'b0;
    bypass[k] <= '0;
    chk_go    <= 1'b1;
    @(posedge clk);
    chk_go <= 1'b0;
    finish_test();
  endtask

  task automatic hold_test();
    word_t pc;
    inst_t nxt;
    test_name = "backpressure";
    pc = rnd(62) << 2;
    issue({12'(rnd(12)), 5'(rnd(5)), `F3_ADD, 5'(rnd(5)), `OP_IMM}, pc);
    // the next inst waits in fetch and must not replace the held one
    nxt = {12'(rnd(12)), 5'(rnd(5)), `F3_ADD, 5'(rnd(5)), `OP_IMM};
    fs         <= '{inst: nxt, pc: pc + 64'd4};
    es_allowin <= 1'b0;
    @(posedge clk);
    chk_hold <= 1'b1;
    repeat (2) @(posedge clk);
    chk_hold   <= 1'b0;
    es_allowin <= 1'b1;
    fs_valid   <= 1'b0;
    @(posedge clk);
    finish_test();
  endtask

  initial begin
    rst_n = 1'b0;
    fs_valid = 1'b1; // a jal waits in fetch through reset
    fs = '{inst: {1'b0, 10'd4, 1'b0, 8'd0, 5'd1, `JAL}, pc: '0};
    es_allowin = 1'b1;
    wb = '0;
    for (int i = 0; i < `NUM_BYPASS; i++) bypass[i] = '0;
    {chk_rst, chk_dec, chk_opnd, chk_br, chk_sq, chk_stall, chk_go, chk_hold} = '0;
    {exp_sel, exp_taken, imm_en} = '0;
    gpr_model[0] = '0;
    repeat (3) @(posedge clk);
    rst_n    <= 1'b1;
    fs_valid <= 1'b0;
    chk_rst  <= 1'b1;
    repeat (2) @(posedge clk);
    chk_rst <= 1'b0;
    finish_test();
    for (int r = 1; r < `GPR_NUM; r++) begin
      gpr_model[r] = rnd(64);
      @(posedge clk);
      wb <= '{wen: 1'b1, addr: gpr_addr_t'(r), data: gpr_model[r]};
    end
    @(posedge clk);
    wb <= '0;
    @(posedge clk);
    for (int n = 0; n < 32; n++) decode_test(n % 8);
    for (int n = 0; n < 20; n++) forward_test();
    for (int n = 0; n < 24; n++) branch_test(n % 6);
    repeat (3) ebreak_test();
    repeat (3) hold_test();
    repeat (2) @(posedge clk);
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
